/* build.f */
+incdir+design
design/cachePkg.sv
design/cacheController.sv
design/sramController.sv
design/memStage.sv
tb/memStageTb.sv

/* Bender.yml */
package:
  name: memstage

sources:
  - include_dirs:
      - design
    files:
      - design/cachePkg.sv
      - design/cacheController.sv
      - design/sramController.sv
      - design/memStage.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/memStageTb.sv

/* tb/memStageTb.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module memStageTb;

    import cachePkg::*;

    localparam int ACCESS_LIMIT = 4 * `SRAM_WAIT + 8;   // cycles before a request counts as hung

    logic                clk;
    logic                rst;
    memReq_t             req;
    logic [31:0]         rData;
    logic                ready;
    cacheStats_t         stats;

    memStage i_dut (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .rData (rData),
        .ready (ready),
        .stats (stats)
    );

    always #20 clk = ~clk;   // 40 ns period

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [31:0]       memModel [logic [16:0]];   // keyed by word address bits 18 down to 2
    logic              modelValid [2][`SETS];
    logic [`TAG_W-1:0] modelTag   [2][`SETS];
    logic              modelMru   [`SETS];        // most recently used way per set
    int                modelReads = 0;
    int                modelHits  = 0;

    int                errors = 0;
    int                checks = 0;
    logic [31:0]       expData;
    logic              expHit;
    logic [31:0]       lcgState;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] lineAdr(input int tag, input int index, input logic hiWord);
        return {13'd0, tag[9:0], index[5:0], hiWord, 2'b00};
    endfunction

    // way that holds the address, or -1 when the set misses
    function automatic int modelWay(input logic [31:0] adr);
        cacheAdr_t a;
        a = cacheAdr_t'(adr[18:0]);
        for (int w = 0; w < 2; w++) begin
            if (modelValid[w][a.index] && modelTag[w][a.index] == a.tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    // expected word of a read and whether it should hit
    function automatic logic expectRead(input logic [31:0] adr, output logic [31:0] word);
        word = memModel.exists(adr[18:2]) ? memModel[adr[18:2]] : 32'd0;
        return modelWay(adr) >= 0;
    endfunction

    task automatic updateModel(input logic rd, input logic [31:0] adr, input logic [31:0] data);
        cacheAdr_t a;
        int        way;
        int        fill;
        a   = cacheAdr_t'(adr[18:0]);
        way = modelWay(adr);
        if (rd) begin
            modelReads++;
            if (way >= 0) begin
                modelHits++;
                modelMru[a.index] = way[0];
            end else begin
                fill = modelMru[a.index] ? 0 : 1;   // the older way takes the new line
                modelValid[fill][a.index] = 1'b1;
                modelTag[fill][a.index]   = a.tag;
                modelMru[a.index]         = fill[0];
            end
        end else begin
            memModel[adr[18:2]] = data;   // writes go around the cache and the line only loses its valid bit
            if (way >= 0) begin
                modelValid[way][a.index] = 1'b0;
                modelMru[a.index]        = ~way[0];
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checks++;
        if (actVal !== expVal) begin
            errors++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
        end
    endtask

    // counts request cycles and checks data and latency when ready shows up
    int waitCycles = 0;
    always @(negedge clk) begin
        if (rst || !(req.rdEn || req.wrEn)) begin
            waitCycles = 0;
        end else begin
            waitCycles = waitCycles + 1;
            if (ready) begin
                if (req.rdEn) begin
                    checkValue("rData", expData, rData);
                end
                checkValue("ready cycle", (req.rdEn && expHit) ? 1 : `SRAM_WAIT, waitCycles);
                waitCycles = 0;
            end
        end
    end

    // one request is held until ready and then the counters are compared
    task automatic runAccess(input logic rd, input logic [31:0] adr, input logic [31:0] data);
        memReq_t     nextReq;
        logic [31:0] word;
        int          spent;
        expHit        = rd && expectRead(adr, word);
        expData       = word;
        nextReq.rdEn  = rd;
        nextReq.wrEn  = !rd;
        nextReq.adr   = adr;
        nextReq.wData = data;
        @(posedge clk);
        req <= nextReq;
        @(negedge clk);
        spent = 1;
        while (!ready && spent < ACCESS_LIMIT) begin
            @(negedge clk);
            spent++;
        end
        if (!ready) begin
            $display("timeout: no ready within %0d cycles for a %s at address %h",
                     ACCESS_LIMIT, rd ? "read" : "write", adr);
            $display("CHECKS FAILED");
            $finish;
        end else begin
            @(posedge clk);
            req <= '0;
            updateModel(rd, adr, data);
            @(negedge clk);
            checkValue("stats.readCnt", modelReads, stats.readCnt);
            checkValue("stats.hitCnt", modelHits, stats.hitCnt);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] r;
        logic [31:0] adr;
        clk      = 1'b0;
        rst     <= 1'b1;
        req     <= '0;
        lcgState = 32'h9948;
        for (int s = 0; s < `SETS; s++) begin
            modelValid[0][s] = 1'b0;
            modelValid[1][s] = 1'b0;
            modelMru[s]      = 1'b0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        runAccess(1'b0, lineAdr(7, 10, 1'b0), 32'hcafe0001);   // write then read back
        runAccess(1'b1, lineAdr(7, 10, 1'b0), 32'd0);
        runAccess(1'b1, lineAdr(9, 11, 1'b0), 32'd0);          // never written so it reads zero
        runAccess(1'b1, lineAdr(7, 10, 1'b0), 32'd0);          // hit in the first cycle

        // three tags share set 20 and C takes the way of B
        for (int t = 1; t <= 3; t++) begin
            runAccess(1'b0, lineAdr(t, 20, 1'b0), 32'h10000000 + t);
        end
        runAccess(1'b1, lineAdr(1, 20, 1'b0), 32'd0);
        runAccess(1'b1, lineAdr(2, 20, 1'b0), 32'd0);
        runAccess(1'b1, lineAdr(1, 20, 1'b0), 32'd0);
        runAccess(1'b1, lineAdr(3, 20, 1'b0), 32'd0);
        runAccess(1'b1, lineAdr(1, 20, 1'b0), 32'd0);
        runAccess(1'b1, lineAdr(2, 20, 1'b0), 32'd0);

        // a write to a cached line drops it and the refetch brings both new words in
        runAccess(1'b0, lineAdr(7, 10, 1'b0), 32'hbeef0002);
        runAccess(1'b0, lineAdr(7, 10, 1'b1), 32'hbeef1002);
        runAccess(1'b1, lineAdr(7, 10, 1'b0), 32'd0);
        runAccess(1'b1, lineAdr(7, 10, 1'b1), 32'd0);

        // four tags over four sets keeps the LRU busy
        for (int n = 0; n < 300; n++) begin
            lcgState = lcgNext(lcgState);
            r        = lcgState;
            adr      = lineAdr(r[31:30], r[29:28], r[27]);
            if (r[26:24] < 3'd5) begin
                runAccess(1'b1, adr, 32'd0);
            end else begin
                lcgState = lcgNext(lcgState);
                runAccess(1'b0, adr, lcgState);
            end
            repeat (r[23:22]) @(posedge clk);
        end

        $display("summary: %0d checks, %0d errors, %0d reads, %0d hits",
                 checks, errors, modelReads, modelHits);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* design/memStage.sv */
`timescale 1ns/1ps

module memStage (
    input  logic                   clk,
    input  logic                   rst,
    input  cachePkg::memReq_t      req,
    output logic [31:0]            rData,
    output logic                   ready,
    output cachePkg::cacheStats_t  stats
);

    import cachePkg::*;

    sramReq_t    sramReq;
    logic [63:0] sramRData;
    logic        sramReady;

    // read cache with write-around in front of the SRAM
    cacheController i_cache (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .rData     (rData),
        .ready     (ready),
        .sramReq   (sramReq),
        .sramRData (sramRData),
        .sramReady (sramReady),
        .stats     (stats)
    );

    sramController i_sram (
        .clk       (clk),
        .rst       (rst),
        .sramReq   (sramReq),
        .sramRData (sramRData),
        .sramReady (sramReady)
    );

endmodule

/* design/sramController.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module sramController (
    input  logic                clk,
    input  logic                rst,
    input  cachePkg::sramReq_t  sramReq,
    output logic [63:0]         sramRData,
    output logic                sramReady
);

    import cachePkg::*;

    localparam int LINE_W = $clog2(`SRAM_LINES);
    localparam int CNT_W  = $clog2(`SRAM_WAIT + 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [63:0]       storage [`SRAM_LINES];
    logic [LINE_W-1:0] lineIdx;
    logic              reqActive;

    assign lineIdx   = sramReq.adr[LINE_W+2:3];   // aligned 64-bit line
    assign reqActive = sramReq.rdEn | sramReq.wrEn;

    // behavioral array starts out cleared
    initial begin
        for (int i = 0; i < `SRAM_LINES; i++) begin
            storage[i] = '0;
        end
    end

    assign sramRData = storage[lineIdx];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wait-state sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    sramState_t       state;
    logic [CNT_W-1:0] waitCnt;   // request cycles already spent

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= sramIdle;
            waitCnt <= '0;
        end else begin
            case (state)
                sramIdle: begin
                    // waitCnt is still nonzero in the cycle after sramDone,
                    // which makes that cycle a dead one
                    if (reqActive && waitCnt == '0) begin
                        state   <= sramAccess;
                        waitCnt <= CNT_W'(1);
                    end else begin
                        waitCnt <= '0;
                    end
                end
                sramAccess: begin
                    waitCnt <= waitCnt + CNT_W'(1);
                    if (waitCnt == CNT_W'(`SRAM_WAIT - 2)) begin
                        state <= sramDone;
                    end
                end
                sramDone: state <= sramIdle;   // ready is high for this one cycle
                default:  state <= sramIdle;
            endcase
        end
    end

    assign sramReady = (state == sramDone);

    // the word lands on the same edge the requester sees ready
    always_ff @(posedge clk) begin
        if (sramReady && sramReq.wrEn) begin
            if (sramReq.adr[2]) begin
                storage[lineIdx][63:32] <= sramReq.wData;
            end else begin
                storage[lineIdx][31:0] <= sramReq.wData;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assert property (@(posedge clk) disable iff (rst) sramReady |-> reqActive)
        else $error("SRAM ready with no request pending");

    // the cache must hold address, data and enables through the wait states
    assert property (@(posedge clk) disable iff (rst)
        (state == sramAccess) |-> $stable(sramReq))
        else $error("SRAM request changed during access");

endmodule

/* design/cacheController.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cacheController (
    input  logic                   clk,
    input  logic                   rst,
    input  cachePkg::memReq_t      req,
    output logic [31:0]            rData,
    output logic                   ready,
    output cachePkg::sramReq_t     sramReq,
    input  logic [63:0]            sramRData,
    input  logic                   sramReady,
    output cachePkg::cacheStats_t  stats
);

    import cachePkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address split and storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    cacheAdr_t adrSplit;
    logic [`INDEX_W-1:0] idx;
    logic                upperWord;   // offset bit 2 picks the high word of a line

    assign adrSplit  = cacheAdr_t'(req.adr[`TAG_W+`INDEX_W+`OFFSET_W-1:0]);
    assign idx       = adrSplit.index;
    assign upperWord = adrSplit.offset[`OFFSET_W-1];

    // two ways, each a 64-bit line with its tag
    logic [63:0]         wayData  [2][`SETS];
    logic [`TAG_W-1:0]   wayTag   [2][`SETS];
    logic [`SETS-1:0]    wayValid [2];

    // per set, the index of the most recently used way
    logic [`SETS-1:0]    lruMru;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hit detection and word select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [1:0] wayHit;
    logic       hit;
    logic       hitWay;
    logic       fillWay;
    logic       fillNow;
    logic       readDone;
    logic       writeDone;

    function automatic logic [31:0] selectWord(input logic [63:0] line, input logic hi);
        return hi ? line[63:32] : line[31:0];
    endfunction

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            // valid gates out the tag, which holds garbage until the first fill
            wayHit[w] = wayValid[w][idx] && (wayTag[w][idx] == adrSplit.tag);
        end
    end

    assign hit     = |wayHit;
    assign hitWay  = wayHit[1];
    assign fillWay = ~lruMru[idx];     // the older way of the set

    // a hit answers in the same cycle, a miss waits on the SRAM
    assign ready = (req.rdEn & hit) | sramReady;
    assign rData = hit ? selectWord(wayData[hitWay][idx], upperWord)
                       : selectWord(sramRData, upperWord);

    assign readDone  = req.rdEn & ready;
    assign fillNow   = req.rdEn & ~hit & sramReady;
    assign writeDone = req.wrEn & sramReady;

    // reads go out only on a miss, writes always go around the cache
    always_comb begin
        sramReq.rdEn  = req.rdEn & ~hit;
        sramReq.wrEn  = req.wrEn;
        sramReq.adr   = req.adr;
        sramReq.wData = req.wData;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wayValid[0] <= '0;
            wayValid[1] <= '0;
            lruMru      <= '0;
            stats       <= '0;
        end else begin
            if (readDone) begin
                stats.readCnt <= stats.readCnt + 32'd1;
                if (hit) begin
                    stats.hitCnt <= stats.hitCnt + 32'd1;
                    lruMru[idx]  <= hitWay;
                end else begin
                    wayValid[fillWay][idx] <= 1'b1;   // line lands on the ready edge
                    lruMru[idx]            <= fillWay;
                end
            end

            // a write never overlaps a read, so these cannot collide
            if (writeDone && hit) begin
                wayValid[hitWay][idx] <= 1'b0;
                lruMru[idx]           <= ~hitWay;     // invalid way goes first next time
            end
        end
    end

    // line payload and tag, only meaningful under the valid bit
    always_ff @(posedge clk) begin
        if (fillNow) begin
            wayData[fillWay][idx] <= sramRData;
            wayTag[fillWay][idx]  <= adrSplit.tag;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the requester side must never ask for both at once
    assert property (@(posedge clk) disable iff (rst) !(req.rdEn && req.wrEn))
        else $error("read and write enables high together");

    // a fill only ever targets a way that missed, so a tag lives in one way only
    assert property (@(posedge clk) disable iff (rst)
        (req.rdEn || req.wrEn) |-> $onehot0(wayHit))
        else $error("address hit in both ways of set %0d", idx);

endmodule

/* design/cachePkg.sv */
`include "cache_consts.svh"

package cachePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request buses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // processor side, held until ready is seen high at an edge
    typedef struct packed {
        logic        rdEn;
        logic        wrEn;
        logic [31:0] adr;
        logic [31:0] wData;
    } memReq_t;

    // cache to SRAM controller, same handshake
    typedef struct packed {
        logic        rdEn;
        logic        wrEn;
        logic [31:0] adr;
        logic [31:0] wData;
    } sramReq_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cache bookkeeping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // low 19 address bits as the cache sees them
    typedef struct packed {
        logic [`TAG_W-1:0]    tag;
        logic [`INDEX_W-1:0]  index;
        logic [`OFFSET_W-1:0] offset;
    } cacheAdr_t;

    typedef struct packed {
        logic [31:0] readCnt;   // completed reads
        logic [31:0] hitCnt;    // reads served from a way
    } cacheStats_t;

    typedef enum logic [1:0] {
        sramIdle,
        sramAccess,
        sramDone
    } sramState_t;

endpackage

/* design/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache address split
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// a line is two 32-bit words, so 8 bytes
`define OFFSET_W 3
`define INDEX_W 6
`define TAG_W 10      // address bits 18 down to 9
`define SETS 64       // one set per index value

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SRAM side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// cycles from request to ready, counting the first request cycle
// the controller sequence needs at least 3
`define SRAM_WAIT 4
`define SRAM_LINES 65536   // 64-bit lines, addressed by bits 18 down to 3

`endif
